// File: hdl/bm_cfg_pkg.sv
package bm_cfg_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    localparam int IFM_DW    = 32;    // one pixel word from the stream
    localparam int FILTER_DW = 72;    // one 3x3 kernel of 8-bit taps

    // layer config
    localparam int W_CHANNEL = 10;    // q_channel width

    // ------------------------------
    // buffer depths
    // ------------------------------
    // sized for simulation and overridable from the top level
    localparam int FM_DEPTH_DEFAULT     = 1024;
    localparam int FILTER_DEPTH_DEFAULT = 64;    // 4 banks share one address

endpackage

// File: hdl/bm_word_pkg.sv
package bm_word_pkg;

    localparam int N_LANES     = 4;    // filter banks = byte lanes per word
    localparam int KERNEL_TAPS = 9;    // 3x3 kernel
    localparam int TAP_W       = 8;

    // ------------------------------
    // stream word, two views
    // ------------------------------
    // ifm load reads the whole word as a pixel, filter load splits it
    // into one tap per bank (lane j -> filter j)
    typedef union packed {
        logic [N_LANES*TAP_W-1:0]      pixel;
        logic [N_LANES-1:0][TAP_W-1:0] taps;
    } stream_word_u;

endpackage

// File: hdl/bm_dpram.sv
`timescale 1ns/1ps

module bm_dpram #(
    parameter int DEPTH = 1024,
    parameter int DW    = 32
) (
    input  logic                     clk,
    // write port
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [DW-1:0]            wdata,
    // read port
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [DW-1:0]            rdata
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];    // held until the next read
        end
    end

endmodule

// File: hdl/ifm_loader.sv
`timescale 1ns/1ps

module ifm_loader #(
    parameter int FM_DEPTH = bm_cfg_pkg::FM_DEPTH_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rstn,

    input  logic                            load_ifm,
    input  logic                            read_data_vld,
    input  bm_word_pkg::stream_word_u       read_data,

    output logic                            ifm_we,
    output logic [$clog2(FM_DEPTH)-1:0]     ifm_waddr,
    output logic [bm_cfg_pkg::IFM_DW-1:0]   ifm_wdata
);

    logic load_ifm_d;
    logic load_start;    // rising edge of load_ifm
    logic accept;

    assign load_start = load_ifm & ~load_ifm_d;
    assign accept     = load_ifm & read_data_vld;

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_ifm_d <= 1'b0;
            ifm_we     <= 1'b0;
            ifm_waddr  <= '0;
        end else begin
            load_ifm_d <= load_ifm;
            ifm_we     <= accept;    // write lands one edge after accept

            // a new load always begins at address 0
            if (load_start) begin
                ifm_waddr <= '0;
            end else if (ifm_we) begin
                ifm_waddr <= ifm_waddr + 1'b1;
            end
        end
    end

    // ------------------------------
    // data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            ifm_wdata <= read_data.pixel;
        end
    end

endmodule

// File: hdl/kernel_packer.sv
`timescale 1ns/1ps

module kernel_packer #(
    parameter int FILTER_DEPTH = bm_cfg_pkg::FILTER_DEPTH_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rstn,

    input  logic                              load_filter,
    input  logic                              read_data_vld,
    input  bm_word_pkg::stream_word_u         read_data,
    input  logic [bm_cfg_pkg::W_CHANNEL-1:0]  q_channel,

    output logic                              flt_we,
    output logic [$clog2(FILTER_DEPTH)-1:0]   flt_waddr,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata0,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata1,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata2,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata3,
    output logic                              flt_last
);

    import bm_cfg_pkg::*;
    import bm_word_pkg::*;

    localparam int AW = $clog2(FILTER_DEPTH);
    localparam int TW = $clog2(KERNEL_TAPS);

    // ------------------------------
    // arming
    // ------------------------------
    logic load_filter_d;
    logic armed;
    logic arm_now;     // armed, or armed by this very edge
    logic f_in_vld;
    logic f_start;     // first word of a load

    assign f_in_vld = load_filter & read_data_vld;
    assign arm_now  = armed | (load_filter & ~load_filter_d);
    assign f_start  = arm_now & f_in_vld;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_filter_d <= 1'b0;
            armed         <= 1'b0;
        end else begin
            load_filter_d <= load_filter;
            armed         <= arm_now & ~f_in_vld;
        end
    end

    // ------------------------------
    // tap counter, 0..8
    // ------------------------------
    logic [TW-1:0] tap_cnt;
    logic [TW-1:0] tap_idx;    // position of the current word
    logic          kcommit;    // ninth word accepted
    logic          kcommit_d;

    assign tap_idx = f_start ? '0 : tap_cnt;
    assign kcommit = f_in_vld & (tap_idx == TW'(KERNEL_TAPS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_cnt <= '0;
        end else if (f_in_vld) begin
            tap_cnt <= kcommit ? '0 : tap_idx + 1'b1;
        end
    end

    // tap k of lane j -> bits 8k+7:8k of bank j
    logic [FILTER_DW-1:0] acc [N_LANES];

    always_ff @(posedge clk) begin
        if (f_in_vld) begin
            for (int j = 0; j < N_LANES; j++) begin
                acc[j][TAP_W*tap_idx +: TAP_W] <= read_data.taps[j];
            end
        end
    end

    // ------------------------------
    // commit and address
    // ------------------------------
    logic [W_CHANNEL+1:0] kern_span;    // 4*q_channel - 1
    logic [AW-1:0]        last_addr;

    assign kern_span = {q_channel, 2'b00} - 1'b1;
    assign last_addr = kern_span[AW-1:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kcommit_d <= 1'b0;
            flt_waddr <= '0;
        end else begin
            kcommit_d <= kcommit;
            if (f_start) begin
                flt_waddr <= '0;
            end else if (kcommit_d) begin
                flt_waddr <= (flt_waddr == last_addr) ? '0 : flt_waddr + 1'b1;
            end
        end
    end

    assign flt_we     = kcommit_d;
    assign flt_last   = kcommit_d & (flt_waddr == last_addr);
    assign flt_wdata0 = acc[0];
    assign flt_wdata1 = acc[1];
    assign flt_wdata2 = acc[2];
    assign flt_wdata3 = acc[3];

endmodule

// File: hdl/buffer_store.sv
`timescale 1ns/1ps

module buffer_store #(
    parameter int FM_DEPTH     = bm_cfg_pkg::FM_DEPTH_DEFAULT,
    parameter int FILTER_DEPTH = bm_cfg_pkg::FILTER_DEPTH_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              load_filter,

    // ifm write
    input  logic                              ifm_we,
    input  logic [$clog2(FM_DEPTH)-1:0]       ifm_waddr,
    input  logic [bm_cfg_pkg::IFM_DW-1:0]     ifm_wdata,

    // filter write
    input  logic                              flt_we,
    input  logic [$clog2(FILTER_DEPTH)-1:0]   flt_waddr,
    input  logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata0,
    input  logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata1,
    input  logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata2,
    input  logic [bm_cfg_pkg::FILTER_DW-1:0]  flt_wdata3,
    input  logic                              flt_last,

    // ifm read
    input  logic                              ifm_rd_en,
    input  logic [$clog2(FM_DEPTH)-1:0]       ifm_rd_addr,
    output logic [bm_cfg_pkg::IFM_DW-1:0]     ifm_rd_data,

    // filter read
    input  logic                              fb_req,
    input  logic [$clog2(FILTER_DEPTH)-1:0]   fb_addr,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data0,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data1,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data2,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data3,
    output logic                              fb_req_possible
);

    import bm_cfg_pkg::*;
    import bm_word_pkg::*;

    // ------------------------------
    // ifm buffer
    // ------------------------------
    bm_dpram #(
        .DEPTH (FM_DEPTH),
        .DW    (IFM_DW)
    ) u_ifm_buf (
        .clk   (clk),
        .we    (ifm_we),
        .waddr (ifm_waddr),
        .wdata (ifm_wdata),
        .re    (ifm_rd_en),
        .raddr (ifm_rd_addr),
        .rdata (ifm_rd_data)
    );

    // ------------------------------
    // filter banks
    // ------------------------------
    logic [FILTER_DW-1:0] bank_wdata [N_LANES];
    logic [FILTER_DW-1:0] bank_rdata [N_LANES];

    assign bank_wdata[0] = flt_wdata0;
    assign bank_wdata[1] = flt_wdata1;
    assign bank_wdata[2] = flt_wdata2;
    assign bank_wdata[3] = flt_wdata3;

    // all banks share the write address and the read request
    for (genvar j = 0; j < N_LANES; j++) begin : g_bank
        bm_dpram #(
            .DEPTH (FILTER_DEPTH),
            .DW    (FILTER_DW)
        ) u_filter_buf (
            .clk   (clk),
            .we    (flt_we),
            .waddr (flt_waddr),
            .wdata (bank_wdata[j]),
            .re    (fb_req),
            .raddr (fb_addr),
            .rdata (bank_rdata[j])
        );
    end

    assign fb_data0 = bank_rdata[0];
    assign fb_data1 = bank_rdata[1];
    assign fb_data2 = bank_rdata[2];
    assign fb_data3 = bank_rdata[3];

    // ready flag set by the last kernel write and dropped by a new filter load
    logic load_filter_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_filter_d   <= 1'b0;
            fb_req_possible <= 1'b0;
        end else begin
            load_filter_d <= load_filter;
            if (load_filter & ~load_filter_d) begin
                fb_req_possible <= 1'b0;
            end else if (flt_we & flt_last) begin
                fb_req_possible <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/buffer_manager.sv
`timescale 1ns/1ps

module buffer_manager #(
    parameter int FM_DEPTH     = bm_cfg_pkg::FM_DEPTH_DEFAULT,
    parameter int FILTER_DEPTH = bm_cfg_pkg::FILTER_DEPTH_DEFAULT
) (
    input  logic                              clk,
    input  logic                              rstn,

    input  logic [bm_cfg_pkg::W_CHANNEL-1:0]  q_channel,
    input  logic                              load_ifm,
    input  logic                              load_filter,

    // stream in
    input  bm_word_pkg::stream_word_u         read_data,
    input  logic                              read_data_vld,

    // compute engine side
    input  logic                              ifm_rd_en,
    input  logic [$clog2(FM_DEPTH)-1:0]       ifm_rd_addr,
    output logic [bm_cfg_pkg::IFM_DW-1:0]     ifm_rd_data,

    input  logic                              fb_req,
    input  logic [$clog2(FILTER_DEPTH)-1:0]   fb_addr,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data0,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data1,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data2,
    output logic [bm_cfg_pkg::FILTER_DW-1:0]  fb_data3,
    output logic                              fb_req_possible
);

    import bm_cfg_pkg::*;

    localparam int FM_AW  = $clog2(FM_DEPTH);
    localparam int FLT_AW = $clog2(FILTER_DEPTH);

    // loader -> store
    logic                 ifm_we;
    logic [FM_AW-1:0]     ifm_waddr;
    logic [IFM_DW-1:0]    ifm_wdata;

    // packer -> store
    logic                 flt_we;
    logic [FLT_AW-1:0]    flt_waddr;
    logic [FILTER_DW-1:0] flt_wdata0;
    logic [FILTER_DW-1:0] flt_wdata1;
    logic [FILTER_DW-1:0] flt_wdata2;
    logic [FILTER_DW-1:0] flt_wdata3;
    logic                 flt_last;

    ifm_loader #(
        .FM_DEPTH (FM_DEPTH)
    ) u_ifm_loader (
        .clk           (clk),
        .rstn          (rstn),
        .load_ifm      (load_ifm),
        .read_data_vld (read_data_vld),
        .read_data     (read_data),
        .ifm_we        (ifm_we),
        .ifm_waddr     (ifm_waddr),
        .ifm_wdata     (ifm_wdata)
    );

    kernel_packer #(
        .FILTER_DEPTH (FILTER_DEPTH)
    ) u_kernel_packer (
        .clk           (clk),
        .rstn          (rstn),
        .load_filter   (load_filter),
        .read_data_vld (read_data_vld),
        .read_data     (read_data),
        .q_channel     (q_channel),
        .flt_we        (flt_we),
        .flt_waddr     (flt_waddr),
        .flt_wdata0    (flt_wdata0),
        .flt_wdata1    (flt_wdata1),
        .flt_wdata2    (flt_wdata2),
        .flt_wdata3    (flt_wdata3),
        .flt_last      (flt_last)
    );

    buffer_store #(
        .FM_DEPTH     (FM_DEPTH),
        .FILTER_DEPTH (FILTER_DEPTH)
    ) u_buffer_store (
        .clk             (clk),
        .rstn            (rstn),
        .load_filter     (load_filter),
        .ifm_we          (ifm_we),
        .ifm_waddr       (ifm_waddr),
        .ifm_wdata       (ifm_wdata),
        .flt_we          (flt_we),
        .flt_waddr       (flt_waddr),
        .flt_wdata0      (flt_wdata0),
        .flt_wdata1      (flt_wdata1),
        .flt_wdata2      (flt_wdata2),
        .flt_wdata3      (flt_wdata3),
        .flt_last        (flt_last),
        .ifm_rd_en       (ifm_rd_en),
        .ifm_rd_addr     (ifm_rd_addr),
        .ifm_rd_data     (ifm_rd_data),
        .fb_req          (fb_req),
        .fb_addr         (fb_addr),
        .fb_data0        (fb_data0),
        .fb_data1        (fb_data1),
        .fb_data2        (fb_data2),
        .fb_data3        (fb_data3),
        .fb_req_possible (fb_req_possible)
    );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD = 20.0    // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: test/buffer_manager_sva.sv
`timescale 1ns/1ps

module buffer_manager_sva #(
    parameter int FILTER_DEPTH = bm_cfg_pkg::FILTER_DEPTH_DEFAULT
) (
    input logic                                        clk,
    input logic                                        rstn,
    input logic                                        load_filter,
    input logic [$clog2(bm_word_pkg::KERNEL_TAPS)-1:0] tap_cnt,
    input logic                                        flt_we,
    input logic [$clog2(FILTER_DEPTH)-1:0]             flt_waddr,
    input logic [$clog2(FILTER_DEPTH)-1:0]             last_addr
);

    import bm_word_pkg::*;

    int n_fail = 0;    // count of failed checks

    a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
        tap_cnt <= KERNEL_TAPS - 1)
        else begin
            n_fail++;
            $error("tap counter left the range 0..8");
        end

    // kernel writes only inside a filter load
    a_we_in_load: assert property (@(posedge clk) disable iff (!rstn)
        flt_we |-> load_filter)
        else begin
            n_fail++;
            $error("kernel write while load_filter is low");
        end

    a_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        flt_waddr <= last_addr)
        else begin
            n_fail++;
            $error("filter write address above the last address");
        end

endmodule

bind kernel_packer buffer_manager_sva #(
    .FILTER_DEPTH (FILTER_DEPTH)
) u_sva (
    .clk         (clk),
    .rstn        (rstn),
    .load_filter (load_filter),
    .tap_cnt     (tap_cnt),
    .flt_we      (flt_we),
    .flt_waddr   (flt_waddr),
    .last_addr   (last_addr)
);

// File: test/tb_buffer_manager.sv
`timescale 1ns/1ps

module tb_buffer_manager;

    import bm_cfg_pkg::*;
    import bm_word_pkg::*;

    localparam int FM_DEPTH     = FM_DEPTH_DEFAULT;
    localparam int FILTER_DEPTH = FILTER_DEPTH_DEFAULT;
    localparam int FM_AW        = $clog2(FM_DEPTH);
    localparam int FLT_AW       = $clog2(FILTER_DEPTH);
    localparam int READY_WAIT   = 20;    // cycles allowed for fb_req_possible to rise

    logic                 clk;
    logic                 rstn;
    logic [W_CHANNEL-1:0] q_channel;
    logic                 load_ifm;
    logic                 load_filter;
    stream_word_u         read_data;
    logic                 read_data_vld;
    logic                 ifm_rd_en;
    logic [FM_AW-1:0]     ifm_rd_addr;
    logic [IFM_DW-1:0]    ifm_rd_data;
    logic                 fb_req;
    logic [FLT_AW-1:0]    fb_addr;
    logic [FILTER_DW-1:0] fb_data0;
    logic [FILTER_DW-1:0] fb_data1;
    logic [FILTER_DW-1:0] fb_data2;
    logic [FILTER_DW-1:0] fb_data3;
    logic                 fb_req_possible;

    clk_gen #(.PERIOD(20.0)) u_clk_gen (.clk(clk));

    buffer_manager #(
        .FM_DEPTH     (FM_DEPTH),
        .FILTER_DEPTH (FILTER_DEPTH)
    ) UUT (
        .clk             (clk),
        .rstn            (rstn),
        .q_channel       (q_channel),
        .load_ifm        (load_ifm),
        .load_filter     (load_filter),
        .read_data       (read_data),
        .read_data_vld   (read_data_vld),
        .ifm_rd_en       (ifm_rd_en),
        .ifm_rd_addr     (ifm_rd_addr),
        .ifm_rd_data     (ifm_rd_data),
        .fb_req          (fb_req),
        .fb_addr         (fb_addr),
        .fb_data0        (fb_data0),
        .fb_data1        (fb_data1),
        .fb_data2        (fb_data2),
        .fb_data3        (fb_data3),
        .fb_req_possible (fb_req_possible)
    );

    // ------------------------------
    // checking
    // ------------------------------
    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [FILTER_DW-1:0] got,
                               input logic [FILTER_DW-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    always @(negedge clk) begin
        if (UUT.u_kernel_packer.u_sva.n_fail != 0) begin
            $display("an assertion in the kernel packer failed");
            abort_run();
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic drive_word(input logic to_ifm, input logic to_filter,
                              input logic [IFM_DW-1:0] word);
        @(posedge clk);
        load_ifm        <= to_ifm;
        load_filter     <= to_filter;
        read_data_vld   <= 1'b1;
        read_data.pixel <= word;
    endtask

    task automatic end_load();
        @(posedge clk);
        load_ifm      <= 1'b0;
        load_filter   <= 1'b0;
        read_data_vld <= 1'b0;
    endtask

    task automatic read_ifm(input logic [31:0] addr, input logic [IFM_DW-1:0] exp);
        @(posedge clk);
        read_data_vld <= 1'b0;
        ifm_rd_en     <= 1'b1;
        ifm_rd_addr   <= addr[FM_AW-1:0];
        @(posedge clk);
        ifm_rd_en <= 1'b0;    // data registered on this edge
        @(negedge clk);
        check_value("ifm_rd_data", ifm_rd_data, exp);
    endtask

    task automatic read_kernel(input logic [31:0] addr,
                               input logic [FILTER_DW-1:0] e0, input logic [FILTER_DW-1:0] e1,
                               input logic [FILTER_DW-1:0] e2, input logic [FILTER_DW-1:0] e3);
        @(posedge clk);
        read_data_vld <= 1'b0;
        fb_req        <= 1'b1;
        fb_addr       <= addr[FLT_AW-1:0];
        @(posedge clk);
        fb_req <= 1'b0;
        @(negedge clk);
        check_value("fb_data0", fb_data0, e0);
        check_value("fb_data1", fb_data1, e1);
        check_value("fb_data2", fb_data2, e2);
        check_value("fb_data3", fb_data3, e3);
    endtask

    // load lines stay as they are, only the stream goes quiet
    task automatic expect_ready(input logic level);
        int n;
        int limit;
        limit = level ? READY_WAIT : 1;
        for (n = 0; n < limit; n++) begin
            @(posedge clk);
            read_data_vld <= 1'b0;
            @(negedge clk);
            if (fb_req_possible === level) break;
        end
        if (level && n == limit) begin
            $display("timeout: fb_req_possible did not rise within %0d cycles", READY_WAIT);
            abort_run();
        end else begin
            check_value("fb_req_possible", fb_req_possible, level);
        end
    endtask

    task automatic run_stimulus();
        int                   fd;
        string                op;
        string                skip;
        logic [31:0]          addr;
        logic [31:0]          word;
        logic [FILTER_DW-1:0] e0, e1, e2, e3;
        fd = $fopen("test/bm_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/bm_stim.txt");
            abort_run();
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(skip, fd));
                end else if (op == "I") begin
                    void'($fscanf(fd, "%h", word));
                    drive_word(1'b1, 1'b0, word);
                end else if (op == "F") begin
                    for (int k = 0; k < KERNEL_TAPS; k++) begin    // one kernel per line
                        void'($fscanf(fd, "%h", word));
                        drive_word(1'b0, 1'b1, word);
                    end
                end else if (op == "X") begin
                    void'($fscanf(fd, "%h", word));
                    drive_word(1'b0, 1'b0, word);
                end else if (op == "E") begin
                    end_load();
                end else if (op == "R") begin
                    void'($fscanf(fd, "%h %h", addr, word));
                    read_ifm(addr, word);
                end else if (op == "K") begin
                    void'($fscanf(fd, "%h %h %h %h %h", addr, e0, e1, e2, e3));
                    read_kernel(addr, e0, e1, e2, e3);
                end else if (op == "P") begin
                    void'($fscanf(fd, "%h", word));
                    expect_ready(word[0]);
                end else begin
                    $display("unknown opcode %s in the stimulus file", op);
                    abort_run();
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rstn          = 1'b0;
        q_channel     = W_CHANNEL'(1);
        load_ifm      = 1'b0;
        load_filter   = 1'b0;
        read_data     = '0;
        read_data_vld = 1'b0;
        ifm_rd_en     = 1'b0;
        ifm_rd_addr   = '0;
        fb_req        = 1'b0;
        fb_addr       = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        run_stimulus();

        if (UUT.u_kernel_packer.u_sva.n_fail != 0) begin
            $display("%0d assertion failure(s) in the kernel packer",
                     UUT.u_kernel_packer.u_sva.n_fail);
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: test/bm_stim.txt
# op and hex values: I/F/X word(s), R addr pixel, K addr bank0 bank1 bank2 bank3, P level
# F holds the nine words of one kernel, E ends the current load
P 0
I 0badf00d
I 12345678
I 9abcdef0
I 0f1e2d3c
I 55aa33cc
I deadbeef
E
R 0 0badf00d
R 1 12345678
R 2 9abcdef0
R 3 0f1e2d3c
R 4 55aa33cc
R 5 deadbeef
I 00000011
I 00000022
E
R 0 00000011
R 1 00000022
R 2 9abcdef0
X 77777777
X 88888888
E
R 2 9abcdef0
R 5 deadbeef
F 30201000 31211101 32221202 33231303 34241404 35251505 36261606 37271707 38281808
F 70605040 71615141 72625242 73635343 74645444 75655545 76665646 77675747 78685848
F b0a09080 b1a19181 b2a29282 b3a39383 b4a49484 b5a59585 b6a69686 b7a79787 b8a89888
P 0
F f0e0d0c0 f1e1d1c1 f2e2d2c2 f3e3d3c3 f4e4d4c4 f5e5d5c5 f6e6d6c6 f7e7d7c7 f8e8d8c8
P 1
E
K 0 080706050403020100 181716151413121110 282726252423222120 383736353433323130
K 1 484746454443424140 585756555453525150 686766656463626160 787776757473727170
K 2 888786858483828180 989796959493929190 a8a7a6a5a4a3a2a1a0 b8b7b6b5b4b3b2b1b0
K 3 c8c7c6c5c4c3c2c1c0 d8d7d6d5d4d3d2d1d0 e8e7e6e5e4e3e2e1e0 f8f7f6f5f4f3f2f1f0
F 38281808 37271707 36261606 35251505 34241404 33231303 32221202 31211101 30201000
P 0
F 78685848 77675747 76665646 75655545 74645444 73635343 72625242 71615141 70605040
F b8a89888 b7a79787 b6a69686 b5a59585 b4a49484 b3a39383 b2a29282 b1a19181 b0a09080
P 0
F f8e8d8c8 f7e7d7c7 f6e6d6c6 f5e5d5c5 f4e4d4c4 f3e3d3c3 f2e2d2c2 f1e1d1c1 f0e0d0c0
P 1
E
K 0 000102030405060708 101112131415161718 202122232425262728 303132333435363738
K 3 c0c1c2c3c4c5c6c7c8 d0d1d2d3d4d5d6d7d8 e0e1e2e3e4e5e6e7e8 f0f1f2f3f4f5f6f7f8

// File: sim.f
hdl/bm_cfg_pkg.sv
hdl/bm_word_pkg.sv
hdl/bm_dpram.sv
hdl/ifm_loader.sv
hdl/kernel_packer.sv
hdl/buffer_store.sv
hdl/buffer_manager.sv
test/clk_gen.sv
test/buffer_manager_sva.sv
test/tb_buffer_manager.sv
